// ==== rtl/sbq_cfg_macros.svh ====
`ifndef SBQ_CFG_MACROS_SVH
`define SBQ_CFG_MACROS_SVH

// number of queues and length of a soft reset in cycles.
`define SBQ_NUM_QUEUES        2
`define SBQ_RESET_CYCLES      4

// global registers.
`define SBQ_ID_REG            12'h000
`define SBQ_CAP_REG           12'h004

// queue windows start at SBQ_Q_BASE, one window every SBQ_REG_OFFSET bytes.
`define SBQ_Q_BASE            12'h100
`define SBQ_REG_OFFSET        12'h020

// register offsets inside a queue window.
`define SBQ_BASE_LO_OFS       12'h000
`define SBQ_BASE_HI_OFS       12'h004
`define SBQ_CAPACITY_OFS      12'h008
`define SBQ_ENABLE_OFS        12'h00c
`define SBQ_RESET_OFS         12'h010
`define SBQ_STATUS_OFS        12'h014
`define SBQ_OCCUPANCY_OFS     12'h018

`define SBQ_ID_VERSION        32'h5b01_0000
`define SBQ_UNIMPL_VALUE      32'hffff_ffff
`define SBQ_DEFAULT_CAPACITY  32'd2

`endif

// ==== rtl/sbq_apb_pkg.sv ====
package sbq_apb_pkg;

    // request side of the APB4 slave port.
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        logic [31:0] pwdata;
        logic [3:0]  pstrb;
    } apb_req_t;

    // the response carries no pslverr because unmapped reads return a fixed value.
    typedef struct packed {
        logic        pready;
        logic [31:0] prdata;
    } apb_rsp_t;

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS
    } apb_state_e;

    // one-cycle access handed from the bus FSM to the register file.
    typedef struct packed {
        logic        wr_en;
        logic        rd_en;
        logic [11:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
    } reg_access_t;

endpackage

// ==== rtl/sbq_queue_pkg.sv ====
package sbq_queue_pkg;

    // programmed configuration of one queue.
    typedef struct packed {
        logic [63:0] base;
        logic [31:0] capacity;
        logic        enable;
    } queue_cfg_t;

    typedef struct packed {
        logic [31:0] occupancy;
        logic        idle;  // no entries held.
    } queue_status_t;

    // field selected by a decoded register address.
    typedef enum logic [3:0] {
        FIELD_NONE,
        FIELD_ID,
        FIELD_CAP,
        FIELD_BASE_LO,
        FIELD_BASE_HI,
        FIELD_CAPACITY,
        FIELD_ENABLE,
        FIELD_RESET,
        FIELD_STATUS,
        FIELD_OCCUPANCY
    } reg_field_e;

endpackage

// ==== rtl/sbq_apb_fsm.sv ====
`timescale 1ns/1ps

module sbq_apb_fsm
    import sbq_apb_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  apb_req_t    apb_req,
    input  logic [31:0] rd_data,
    output apb_rsp_t    apb_rsp,
    output reg_access_t reg_access
);

    apb_state_e state;
    apb_state_e state_next;
    logic       setup_phase;
    logic       access_phase;

    assign setup_phase  = apb_req.psel && !apb_req.penable;
    assign access_phase = (state == ACCESS) && apb_req.psel && apb_req.penable;

    // SETUP is entered after a transfer completes, ready for a back-to-back setup cycle.
    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (setup_phase) begin
                    state_next = ACCESS;
                end
            end
            SETUP: begin
                if (setup_phase) begin
                    state_next = ACCESS;
                end else if (!apb_req.psel) begin
                    state_next = IDLE;
                end
            end
            ACCESS: begin
                if (!apb_req.psel) begin
                    state_next = IDLE;  // master dropped the transfer.
                end else if (apb_req.penable) begin
                    state_next = SETUP;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // pready is never withheld in ACCESS, so every transfer takes two cycles.
    always_comb begin
        apb_rsp.pready = (state == ACCESS);
        apb_rsp.prdata = rd_data;
    end

    always_comb begin
        reg_access.wr_en = access_phase && apb_req.pwrite;
        reg_access.rd_en = access_phase && !apb_req.pwrite;
        reg_access.addr  = apb_req.paddr;
        reg_access.data  = apb_req.pwdata;
        reg_access.strb  = apb_req.pstrb;
    end

endmodule

// ==== rtl/sbq_queue_regs.sv ====
`timescale 1ns/1ps
`include "sbq_cfg_macros.svh"

module sbq_queue_regs
    import sbq_apb_pkg::*, sbq_queue_pkg::*;
(
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  reg_access_t                             reg_access,
    input  logic          [`SBQ_NUM_QUEUES-1:0]     reset_busy,
    input  logic          [`SBQ_NUM_QUEUES-1:0]     reset_done,
    input  queue_status_t [`SBQ_NUM_QUEUES-1:0]     status,
    output logic          [31:0]                    rd_data,
    output queue_cfg_t    [`SBQ_NUM_QUEUES-1:0]     cfg,
    output logic          [`SBQ_NUM_QUEUES-1:0]     reset_start
);

    localparam int QW = (`SBQ_NUM_QUEUES > 1) ? $clog2(`SBQ_NUM_QUEUES) : 1;

    logic [11:0]   q_off;
    logic [11:0]   win_off;
    logic [QW-1:0] qidx;
    reg_field_e    field;

    function automatic logic [31:0] strb_merge(
        input logic [31:0] old_val,
        input logic [31:0] new_val,
        input logic [3:0]  strb
    );
        logic [31:0] res;
        res = old_val;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = new_val[b*8 +: 8];
            end
        end
        return res;
    endfunction

    assign q_off   = reg_access.addr - `SBQ_Q_BASE;
    assign win_off = q_off % `SBQ_REG_OFFSET;

    // split the address into a queue index and the field inside its window.
    always_comb begin
        field = FIELD_NONE;
        qidx  = '0;
        if (reg_access.addr == `SBQ_ID_REG) begin
            field = FIELD_ID;
        end else if (reg_access.addr == `SBQ_CAP_REG) begin
            field = FIELD_CAP;
        end else if (reg_access.addr >= `SBQ_Q_BASE &&
                     q_off < `SBQ_NUM_QUEUES * `SBQ_REG_OFFSET) begin
            qidx = QW'(q_off / `SBQ_REG_OFFSET);
            case (win_off)
                `SBQ_BASE_LO_OFS:   field = FIELD_BASE_LO;
                `SBQ_BASE_HI_OFS:   field = FIELD_BASE_HI;
                `SBQ_CAPACITY_OFS:  field = FIELD_CAPACITY;
                `SBQ_ENABLE_OFS:    field = FIELD_ENABLE;
                `SBQ_RESET_OFS:     field = FIELD_RESET;
                `SBQ_STATUS_OFS:    field = FIELD_STATUS;
                `SBQ_OCCUPANCY_OFS: field = FIELD_OCCUPANCY;
                default:            field = FIELD_NONE;  // 0x1c and up are holes.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int q = 0; q < `SBQ_NUM_QUEUES; q++) begin
                cfg[q].base     <= '0;
                cfg[q].capacity <= `SBQ_DEFAULT_CAPACITY;
                cfg[q].enable   <= 1'b0;
            end
        end else begin
            for (int q = 0; q < `SBQ_NUM_QUEUES; q++) begin
                if (reset_done[q]) begin
                    // the last soft reset cycle restores the defaults.
                    cfg[q].base     <= '0;
                    cfg[q].capacity <= `SBQ_DEFAULT_CAPACITY;
                    cfg[q].enable   <= 1'b0;
                end else if (reg_access.wr_en && qidx == QW'(q)) begin
                    case (field)
                        FIELD_BASE_LO: begin
                            cfg[q].base[31:0] <= strb_merge(cfg[q].base[31:0],
                                                            reg_access.data, reg_access.strb);
                        end
                        FIELD_BASE_HI: begin
                            cfg[q].base[63:32] <= strb_merge(cfg[q].base[63:32],
                                                             reg_access.data, reg_access.strb);
                        end
                        FIELD_CAPACITY: begin
                            cfg[q].capacity <= strb_merge(cfg[q].capacity,
                                                          reg_access.data, reg_access.strb);
                        end
                        FIELD_ENABLE: cfg[q].enable <= reg_access.data[0];
                        default: ;
                    endcase
                end
            end
        end
    end

    always_comb begin
        for (int q = 0; q < `SBQ_NUM_QUEUES; q++) begin
            reset_start[q] = reg_access.wr_en && field == FIELD_RESET &&
                             qidx == QW'(q) && reg_access.data[0];
        end
    end

    always_comb begin
        rd_data = `SBQ_UNIMPL_VALUE;
        if (reg_access.rd_en) begin
            case (field)
                FIELD_ID:        rd_data = `SBQ_ID_VERSION;
                FIELD_CAP:       rd_data = 32'(`SBQ_NUM_QUEUES);
                FIELD_BASE_LO:   rd_data = cfg[qidx].base[31:0];
                FIELD_BASE_HI:   rd_data = cfg[qidx].base[63:32];
                FIELD_CAPACITY:  rd_data = cfg[qidx].capacity;
                FIELD_ENABLE:    rd_data = {31'd0, cfg[qidx].enable};
                FIELD_RESET:     rd_data = {31'd0, reset_busy[qidx]};  // 1 while in reset.
                FIELD_STATUS:    rd_data = {31'd0, status[qidx].idle};
                FIELD_OCCUPANCY: rd_data = status[qidx].occupancy;
                default:         rd_data = `SBQ_UNIMPL_VALUE;
            endcase
        end
    end

endmodule

// ==== rtl/sbq_reset_timer.sv ====
`timescale 1ns/1ps
`include "sbq_cfg_macros.svh"

module sbq_reset_timer (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [`SBQ_NUM_QUEUES-1:0] start,
    output logic [`SBQ_NUM_QUEUES-1:0] busy,
    output logic [`SBQ_NUM_QUEUES-1:0] done
);

    localparam int CW = $clog2(`SBQ_RESET_CYCLES + 1);

    logic [`SBQ_NUM_QUEUES-1:0][CW-1:0] cnt;

    // a start while counting reloads the full length.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= '0;
        end else begin
            for (int q = 0; q < `SBQ_NUM_QUEUES; q++) begin
                if (start[q]) begin
                    cnt[q] <= CW'(`SBQ_RESET_CYCLES);
                end else if (cnt[q] != '0) begin
                    cnt[q] <= cnt[q] - 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int q = 0; q < `SBQ_NUM_QUEUES; q++) begin
            busy[q] = (cnt[q] != '0);
            done[q] = (cnt[q] == CW'(1));  // last cycle of the reset.
        end
    end

endmodule

// ==== rtl/sbq_occupancy.sv ====
`timescale 1ns/1ps
`include "sbq_cfg_macros.svh"

module sbq_occupancy
    import sbq_queue_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst_n,
    input  queue_cfg_t    [`SBQ_NUM_QUEUES-1:0] cfg,
    input  logic          [`SBQ_NUM_QUEUES-1:0] busy,
    input  logic          [`SBQ_NUM_QUEUES-1:0] push,
    input  logic          [`SBQ_NUM_QUEUES-1:0] pop,
    output queue_status_t [`SBQ_NUM_QUEUES-1:0] status,
    output logic          [`SBQ_NUM_QUEUES-1:0] push_ready,
    output logic          [`SBQ_NUM_QUEUES-1:0] pop_valid
);

    logic [`SBQ_NUM_QUEUES-1:0][31:0] occ;
    logic [`SBQ_NUM_QUEUES-1:0]       push_acc;
    logic [`SBQ_NUM_QUEUES-1:0]       pop_acc;

    // a capacity lowered under the occupancy only stops further pushes.
    always_comb begin
        for (int q = 0; q < `SBQ_NUM_QUEUES; q++) begin
            push_ready[q] = cfg[q].enable && !busy[q] && (occ[q] < cfg[q].capacity);
            pop_valid[q]  = (occ[q] != '0);
            push_acc[q]   = push[q] && push_ready[q];
            pop_acc[q]    = pop[q] && pop_valid[q];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            occ <= '0;
        end else begin
            for (int q = 0; q < `SBQ_NUM_QUEUES; q++) begin
                if (busy[q]) begin
                    occ[q] <= '0;  // soft reset empties the queue.
                end else begin
                    case ({push_acc[q], pop_acc[q]})
                        2'b10:   occ[q] <= occ[q] + 1'b1;
                        2'b01:   occ[q] <= occ[q] - 1'b1;
                        default: occ[q] <= occ[q];
                    endcase
                end
            end
        end
    end

    always_comb begin
        for (int q = 0; q < `SBQ_NUM_QUEUES; q++) begin
            status[q].occupancy = occ[q];
            status[q].idle      = (occ[q] == '0);
        end
    end

endmodule

// ==== rtl/sbq_subsystem.sv ====
`timescale 1ns/1ps
`include "sbq_cfg_macros.svh"

module sbq_subsystem
    import sbq_apb_pkg::*, sbq_queue_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  apb_req_t                   apb_req,
    input  logic [`SBQ_NUM_QUEUES-1:0] push,
    input  logic [`SBQ_NUM_QUEUES-1:0] pop,
    output apb_rsp_t                   apb_rsp,
    output logic [`SBQ_NUM_QUEUES-1:0] push_ready,
    output logic [`SBQ_NUM_QUEUES-1:0] pop_valid
);

    reg_access_t                          reg_access;
    logic          [31:0]                 rd_data;
    queue_cfg_t    [`SBQ_NUM_QUEUES-1:0]  cfg;
    queue_status_t [`SBQ_NUM_QUEUES-1:0]  status;
    logic          [`SBQ_NUM_QUEUES-1:0]  reset_start;
    logic          [`SBQ_NUM_QUEUES-1:0]  reset_busy;
    logic          [`SBQ_NUM_QUEUES-1:0]  reset_done;

    sbq_apb_fsm u_apb_fsm (
        .clk        (clk),
        .rst_n      (rst_n),
        .apb_req    (apb_req),
        .rd_data    (rd_data),
        .apb_rsp    (apb_rsp),
        .reg_access (reg_access)
    );

    sbq_queue_regs u_queue_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .reg_access  (reg_access),
        .reset_busy  (reset_busy),
        .reset_done  (reset_done),
        .status      (status),
        .rd_data     (rd_data),
        .cfg         (cfg),
        .reset_start (reset_start)
    );

    sbq_reset_timer u_reset_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .start (reset_start),
        .busy  (reset_busy),
        .done  (reset_done)
    );

    // the tracker also holds each queue empty while its soft reset runs.
    sbq_occupancy u_occupancy (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg        (cfg),
        .busy       (reset_busy),
        .push       (push),
        .pop        (pop),
        .status     (status),
        .push_ready (push_ready),
        .pop_valid  (pop_valid)
    );

endmodule

// ==== tb/sbq_tb.sv ====
`timescale 1ns/1ps
`include "sbq_cfg_macros.svh"

module sbq_tb
    import sbq_apb_pkg::*;
();

    localparam int NQ             = `SBQ_NUM_QUEUES;
    localparam int NUM_TRANSFERS  = 140;  // bus transfers and push/pop cycles of all tests.
    localparam int TIMEOUT_CYCLES = 2 * NUM_TRANSFERS * 2 + 200;
    localparam logic [11:0] UNMAPPED_ADDRS [6] = '{12'h008, 12'h0fc, 12'h11c,
                                                   12'h13c, 12'h140, 12'hffc};

    logic          clk;
    logic          rst_n;
    apb_req_t      apb_req;
    apb_rsp_t      apb_rsp;
    logic [NQ-1:0] push;
    logic [NQ-1:0] pop;
    logic [NQ-1:0] push_ready;
    logic [NQ-1:0] pop_valid;

    // reference model of the registers and the occupancy of every queue.
    logic [63:0] m_base [NQ];
    logic [31:0] m_cap  [NQ];
    logic        m_en   [NQ];
    logic        m_rst  [NQ];
    logic [31:0] m_occ  [NQ];

    logic [31:0] lcg_state = 32'h3a80361b;
    string       cur_test;
    string       name_q [$];
    logic [31:0] exp_q  [$];
    logic [31:0] act_q  [$];
    string       chk_name;
    logic [31:0] chk_exp;
    logic [31:0] chk_act;
    int          cycle_cnt   = 0;
    int          err_count   = 0;
    int          check_count = 0;
    int          test_count  = 0;
    int          test_errs   = 0;

    sbq_subsystem u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .apb_req    (apb_req),
        .push       (push),
        .pop        (pop),
        .apb_rsp    (apb_rsp),
        .push_ready (push_ready),
        .pop_valid  (pop_valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [11:0] qaddr(input int q, input logic [11:0] ofs);
        return 12'(`SBQ_Q_BASE + q * `SBQ_REG_OFFSET) + ofs;
    endfunction

    function automatic logic [31:0] apply_strobe(input logic [31:0] old_val,
                                                 input logic [31:0] new_val,
                                                 input logic [3:0]  strb);
        logic [31:0] mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_val & ~mask) | (new_val & mask);
    endfunction

    // index of the queue that owns a window address or -1 outside all windows.
    function automatic int window_of(input logic [11:0] addr);
        if (addr < `SBQ_Q_BASE || addr >= `SBQ_Q_BASE + NQ * `SBQ_REG_OFFSET) begin
            return -1;
        end
        return (addr - `SBQ_Q_BASE) / `SBQ_REG_OFFSET;
    endfunction

    function automatic logic [31:0] expected_read(input logic [11:0] addr);
        int          q;
        logic [31:0] val;
        q   = window_of(addr);
        val = `SBQ_UNIMPL_VALUE;
        if (addr == `SBQ_ID_REG) begin
            val = `SBQ_ID_VERSION;
        end else if (addr == `SBQ_CAP_REG) begin
            val = 32'(NQ);
        end else if (q >= 0) begin
            case (addr - qaddr(q, 12'h000))
                `SBQ_BASE_LO_OFS:   val = m_base[q][31:0];
                `SBQ_BASE_HI_OFS:   val = m_base[q][63:32];
                `SBQ_CAPACITY_OFS:  val = m_cap[q];
                `SBQ_ENABLE_OFS:    val = {31'd0, m_en[q]};
                `SBQ_RESET_OFS:     val = {31'd0, m_rst[q]};
                `SBQ_STATUS_OFS:    val = {31'd0, m_occ[q] == 32'd0};
                `SBQ_OCCUPANCY_OFS: val = m_occ[q];
                default:            val = `SBQ_UNIMPL_VALUE;
            endcase
        end
        return val;
    endfunction

    function automatic logic exp_push_ready(input int q);
        return m_en[q] && !m_rst[q] && (m_occ[q] < m_cap[q]);
    endfunction

    task automatic model_defaults(input int q);
        m_base[q] = '0;
        m_cap[q]  = `SBQ_DEFAULT_CAPACITY;
        m_en[q]   = 1'b0;
        m_rst[q]  = 1'b0;
        m_occ[q]  = '0;
    endtask

    task automatic model_write(input logic [11:0] addr, input logic [31:0] data,
                               input logic [3:0] strb);
        int q;
        q = window_of(addr);
        if (q >= 0) begin
            case (addr - qaddr(q, 12'h000))
                `SBQ_BASE_LO_OFS:  m_base[q][31:0]  = apply_strobe(m_base[q][31:0], data, strb);
                `SBQ_BASE_HI_OFS:  m_base[q][63:32] = apply_strobe(m_base[q][63:32], data, strb);
                `SBQ_CAPACITY_OFS: m_cap[q] = apply_strobe(m_cap[q], data, strb);
                `SBQ_ENABLE_OFS:   m_en[q]  = data[0];
                `SBQ_RESET_OFS: begin
                    if (data[0]) begin
                        m_rst[q] = 1'b1;
                        m_occ[q] = '0;  // held empty while in reset.
                    end
                end
                default: ;
            endcase
        end
    endtask

    task automatic post_check(input string name, input logic [31:0] exp, input logic [31:0] act);
        name_q.push_back(name);
        exp_q.push_back(exp);
        act_q.push_back(act);
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        @(negedge clk);
        while (!apb_rsp.pready && n < 4) begin
            @(negedge clk);
            n++;
        end
        if (!apb_rsp.pready) begin
            $display("%s: pready did not rise within 4 cycles of the access phase", cur_test);
            err_count++;
            test_errs++;
        end else if (n != 0) begin
            $display("%s: pready was withheld for %0d access cycles", cur_test, n);
            err_count++;
            test_errs++;
        end
    endtask

    task automatic apb_transfer(input logic write, input logic [11:0] addr,
                                input logic [31:0] wdata, input logic [3:0] strb,
                                output logic [31:0] rdata);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        apb_req.pstrb   = strb;
        @(negedge clk);
        post_check($sformatf("%s pready in setup @%03h", cur_test, addr), 32'd0,
                   32'(apb_rsp.pready));
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        wait_ready();
        rdata = apb_rsp.prdata;  // sampled mid access cycle.
        @(posedge clk);
        #1;
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
        logic [31:0] ignored_rdata;
        apb_transfer(1'b1, addr, data, strb, ignored_rdata);
        model_write(addr, data, strb);
    endtask

    task automatic read_check(input logic [11:0] addr);
        logic [31:0] rdata;
        apb_transfer(1'b0, addr, '0, 4'h0, rdata);
        post_check($sformatf("%s @%03h", cur_test, addr), expected_read(addr), rdata);
    endtask

    task automatic read_queue(input int q);
        for (int i = 0; i < 7; i++) begin
            read_check(qaddr(q, 12'(i * 4)));
        end
    endtask

    task automatic push_pop(input logic [NQ-1:0] push_vec, input logic [NQ-1:0] pop_vec);
        logic [NQ-1:0] ready_exp;
        logic [NQ-1:0] valid_exp;
        push = push_vec;
        pop  = pop_vec;
        @(negedge clk);
        for (int q = 0; q < NQ; q++) begin
            ready_exp[q] = exp_push_ready(q);
            valid_exp[q] = (m_occ[q] != 32'd0);
            post_check($sformatf("%s push_ready[%0d]", cur_test, q),
                       32'(ready_exp[q]), 32'(push_ready[q]));
            post_check($sformatf("%s pop_valid[%0d]", cur_test, q),
                       32'(valid_exp[q]), 32'(pop_valid[q]));
        end
        @(posedge clk);
        #1;
        for (int q = 0; q < NQ; q++) begin
            if (push_vec[q] && ready_exp[q] && !(pop_vec[q] && valid_exp[q])) begin
                m_occ[q] = m_occ[q] + 32'd1;
            end else if (pop_vec[q] && valid_exp[q] && !(push_vec[q] && ready_exp[q])) begin
                m_occ[q] = m_occ[q] - 32'd1;
            end
        end
        push = '0;
        pop  = '0;
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        @(posedge clk);
        #1;
        if (test_errs == 0) begin
            $display("test %s passed", cur_test);
        end else begin
            $display("test %s failed with %0d errors", cur_test, test_errs);
        end
        test_count++;
    endtask

    always @(posedge clk) begin
        while (act_q.size() > 0) begin
            chk_name = name_q.pop_front();
            chk_exp  = exp_q.pop_front();
            chk_act  = act_q.pop_front();
            check_count++;
            if (chk_act !== chk_exp) begin
                $display("mismatch %s: expected %h actual %h", chk_name, chk_exp, chk_act);
                err_count++;
                test_errs++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        logic [31:0] rdata;
        logic [31:0] rnd_data;
        logic [31:0] rnd_strb;
        int          polls;
        rst_n   = 1'b0;
        apb_req = '0;
        push    = '0;
        pop     = '0;
        for (int q = 0; q < NQ; q++) begin
            model_defaults(q);
        end
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        begin_test("reset_values");
        read_check(`SBQ_ID_REG);
        read_check(`SBQ_CAP_REG);
        for (int q = 0; q < NQ; q++) begin
            read_queue(q);
        end
        end_test();

        begin_test("config_rw");
        for (int r = 0; r < 3; r++) begin
            for (int q = 0; q < NQ; q++) begin
                for (int i = 0; i < 4; i++) begin
                    rnd_data = next_random();
                    rnd_strb = next_random();
                    apb_write(qaddr(q, 12'(i * 4)), rnd_data, rnd_strb[31:28]);
                end
                for (int i = 0; i < 4; i++) begin
                    read_check(qaddr(q, 12'(i * 4)));
                end
            end
        end
        end_test();

        begin_test("unmapped");
        for (int i = 0; i < 6; i++) begin
            read_check(UNMAPPED_ADDRS[i]);
            apb_write(UNMAPPED_ADDRS[i], next_random(), 4'hf);
        end
        for (int q = 0; q < NQ; q++) begin
            read_queue(q);
        end
        end_test();

        begin_test("occupancy_limits");
        apb_write(qaddr(0, `SBQ_CAPACITY_OFS), 32'd3, 4'hf);
        apb_write(qaddr(0, `SBQ_ENABLE_OFS), 32'd1, 4'hf);
        apb_write(qaddr(1, `SBQ_ENABLE_OFS), 32'd0, 4'hf);
        repeat (4) push_pop(NQ'(1), '0);  // the fourth push meets push_ready low.
        read_check(qaddr(0, `SBQ_OCCUPANCY_OFS));
        read_check(qaddr(0, `SBQ_STATUS_OFS));
        repeat (3) push_pop('0, NQ'(1));
        read_check(qaddr(0, `SBQ_OCCUPANCY_OFS));
        read_check(qaddr(0, `SBQ_STATUS_OFS));
        end_test();

        begin_test("disabled_queue");
        apb_write(qaddr(1, `SBQ_CAPACITY_OFS), 32'd3, 4'hf);
        repeat (2) push_pop('1, '0);
        read_check(qaddr(0, `SBQ_OCCUPANCY_OFS));
        read_check(qaddr(1, `SBQ_OCCUPANCY_OFS));
        read_check(qaddr(1, `SBQ_STATUS_OFS));
        end_test();

        begin_test("soft_reset");
        apb_write(qaddr(1, `SBQ_ENABLE_OFS), 32'd1, 4'hf);
        push_pop(NQ'(2), '0);
        apb_write(qaddr(0, `SBQ_RESET_OFS), 32'd1, 4'hf);
        read_check(qaddr(0, `SBQ_RESET_OFS));
        polls = 0;
        rdata = 32'd1;
        while (rdata[0] && polls < 8) begin
            apb_transfer(1'b0, qaddr(0, `SBQ_RESET_OFS), '0, 4'h0, rdata);
            polls++;
        end
        if (rdata[0]) begin
            $display("soft_reset: queue 0 still in reset after %0d polls", polls);
            err_count++;
            test_errs++;
        end
        model_defaults(0);
        for (int q = 0; q < NQ; q++) begin
            read_queue(q);
        end
        push_pop('0, '0);
        end_test();

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== sbq_subsystem.f ====
+incdir+rtl
rtl/sbq_apb_pkg.sv
rtl/sbq_queue_pkg.sv
rtl/sbq_apb_fsm.sv
rtl/sbq_queue_regs.sv
rtl/sbq_reset_timer.sv
rtl/sbq_occupancy.sv
rtl/sbq_subsystem.sv
tb/sbq_tb.sv

// ==== Bender.yml ====
package:
  name: sbq_subsystem

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/sbq_apb_pkg.sv
      - rtl/sbq_queue_pkg.sv
      - rtl/sbq_apb_fsm.sv
      - rtl/sbq_queue_regs.sv
      - rtl/sbq_reset_timer.sv
      - rtl/sbq_occupancy.sv
      - rtl/sbq_subsystem.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/sbq_tb.sv
